/* filelist.f */
+incdir+logic
logic/dma_pkg.sv
logic/dma_reg_if.sv
logic/dma_bus_control.sv
logic/dma_channel_regs.sv
logic/dma_transfer_engine.sv
logic/dma_top.sv
sim/dma_clock_gen.sv
sim/dma_tb.sv

/* logic/dma_bus_control.sv */
// Host bus decoder that turns strobes and register address into register commands
`default_nettype none
`include "dma_params.svh"

module dma_bus_control (
    input  wire logic                       clock,
    input  wire logic                       reset,
    input  wire logic                       chip_select_n,
    input  wire logic                       io_read_n,
    input  wire logic                       io_write_n,
    input  wire logic [`DMA_REG_ADDR_W-1:0] address,
    input  wire logic [`DMA_DATA_W-1:0]     data_in,
    input  wire logic                       lock,
    dma_cmd_if.decoder                      cmd_bus
);

    logic                       write_active;
    logic                       write_q;
    logic                       write_fire;
    logic                       read_active;
    logic                       read_q;
    logic                       read_end;
    logic [`DMA_DATA_W-1:0]     wr_data;
    logic [`DMA_REG_ADDR_W-1:0] wr_address;
    logic [`DMA_REG_ADDR_W-1:0] rd_address;

    // Reads and writes at the same address mean different registers
    function automatic dma_pkg::reg_cmd_e decode(input logic [3:0] a, input logic wr);
        dma_pkg::reg_cmd_e c;
        c = dma_pkg::cmd_none;
        if (!a[3]) begin
            if (wr) begin
                c = a[0] ? dma_pkg::cmd_wr_base_count : dma_pkg::cmd_wr_base_addr;
            end else begin
                c = a[0] ? dma_pkg::cmd_rd_cur_count : dma_pkg::cmd_rd_cur_addr;
            end
        end else if (wr) begin
            case (a[2:0])
                3'd0: c = dma_pkg::cmd_wr_command;
                3'd1: c = dma_pkg::cmd_wr_request;
                3'd2: c = dma_pkg::cmd_wr_single_mask;
                3'd3: c = dma_pkg::cmd_wr_mode;
                3'd4: c = dma_pkg::cmd_clr_byte_ptr;
                3'd5: c = dma_pkg::cmd_master_clear;
                3'd6: c = dma_pkg::cmd_clr_mask;
                3'd7: c = dma_pkg::cmd_wr_all_mask;
            endcase
        end else if (a[2:0] == 3'd0) begin
            c = dma_pkg::cmd_rd_status;
        end
        return c;
    endfunction

    assign write_active = ~chip_select_n & ~io_write_n;
    assign read_active  = ~chip_select_n & ~io_read_n & ~lock;

    // Hold data and address while the write strobe is low
    always_ff @(posedge clock) begin
        if (write_active) begin
            wr_data    <= data_in;
            wr_address <= address;
        end
        if (read_active) begin
            rd_address <= address;
        end
    end

    // Strobe edge detection, writes ending under lock are dropped
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            write_q    <= 1'b0;
            write_fire <= 1'b0;
            read_q     <= 1'b0;
            read_end   <= 1'b0;
        end else begin
            write_q    <= write_active;
            write_fire <= write_q & io_write_n & ~lock;
            read_q     <= read_active;
            read_end   <= read_q & io_read_n & ~lock;
        end
    end

    always_comb begin
        cmd_bus.cmd     = dma_pkg::cmd_none;
        cmd_bus.channel = 2'd0;
        if (write_fire) begin
            cmd_bus.cmd     = decode(wr_address, 1'b1);
            cmd_bus.channel = wr_address[2:1];
        end else if (read_active) begin
            cmd_bus.cmd     = decode(address, 1'b0);
            cmd_bus.channel = address[2:1];
        end else if (read_end) begin
            // Repeat the finished read so the register file can act on it
            cmd_bus.cmd     = decode(rd_address, 1'b0);
            cmd_bus.channel = rd_address[2:1];
        end
    end

    assign cmd_bus.wdata    = wr_data;
    assign cmd_bus.read_end = read_end;

endmodule

`default_nettype wire

/* logic/dma_channel_regs.sv */
// Channel address and count registers, mode, mask, request, status and read-back mux
`default_nettype none
`include "dma_params.svh"

module dma_channel_regs (
    input  wire logic                     clock,
    input  wire logic                     reset,
    dma_cmd_if.regs                       cmd_bus,
    dma_chan_if.regs                      chan_bus,
    input  wire logic [`DMA_CHANNELS-1:0] dreq,
    output logic [`DMA_DATA_W-1:0]        data_out
);

    logic [`DMA_ADDR_W-1:0]   base_addr  [`DMA_CHANNELS];
    logic [`DMA_ADDR_W-1:0]   cur_addr   [`DMA_CHANNELS];
    logic [`DMA_COUNT_W-1:0]  base_count [`DMA_CHANNELS];
    logic [`DMA_COUNT_W-1:0]  cur_count  [`DMA_CHANNELS];
    // Mode bits 5:2 only: decrement, autoinit, transfer type
    logic [3:0]               mode_q     [`DMA_CHANNELS];
    logic [`DMA_CHANNELS-1:0] mask;
    logic [`DMA_CHANNELS-1:0] request;
    logic [`DMA_CHANNELS-1:0] tc;
    logic                     ctrl_disable;
    logic                     byte_ptr;
    logic [1:0]               ch;
    logic [1:0]               sel;
    logic [1:0]               tgt;
    logic [3:0]               byte_lsb;
    logic                     master_clear;
    logic                     count_zero;
    logic                     autoinit;
    logic                     decrement;

    assign ch           = cmd_bus.channel;
    assign sel          = chan_bus.select;
    // Mode, request and single mask carry their channel in data bits 1:0
    assign tgt          = cmd_bus.wdata[1:0];
    assign byte_lsb     = {byte_ptr, 3'b000};
    assign master_clear = (cmd_bus.cmd == dma_pkg::cmd_master_clear);
    assign count_zero   = (cur_count[sel] == '0);
    assign autoinit     = mode_q[sel][2];
    assign decrement    = mode_q[sel][3];

    // Control registers
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            mask         <= '1;
            request      <= '0;
            tc           <= '0;
            ctrl_disable <= 1'b0;
            byte_ptr     <= 1'b0;
            for (int i = 0; i < `DMA_CHANNELS; i++) begin
                mode_q[i] <= 4'd0;
            end
        end else if (master_clear) begin
            mask         <= '1;
            request      <= '0;
            tc           <= '0;
            ctrl_disable <= 1'b0;
            byte_ptr     <= 1'b0;
            for (int i = 0; i < `DMA_CHANNELS; i++) begin
                mode_q[i] <= 4'd0;
            end
        end else begin
            case (cmd_bus.cmd)
                dma_pkg::cmd_wr_base_addr,
                dma_pkg::cmd_wr_base_count:  byte_ptr <= ~byte_ptr;
                dma_pkg::cmd_rd_cur_addr,
                dma_pkg::cmd_rd_cur_count: begin
                    if (cmd_bus.read_end) begin
                        byte_ptr <= ~byte_ptr;
                    end
                end
                dma_pkg::cmd_rd_status: begin
                    if (cmd_bus.read_end) begin
                        tc <= '0;
                    end
                end
                dma_pkg::cmd_wr_command:     ctrl_disable <= cmd_bus.wdata[2];
                dma_pkg::cmd_wr_request:     request[tgt] <= cmd_bus.wdata[2];
                dma_pkg::cmd_wr_single_mask: mask[tgt] <= cmd_bus.wdata[2];
                dma_pkg::cmd_wr_mode:        mode_q[tgt] <= cmd_bus.wdata[5:2];
                dma_pkg::cmd_wr_all_mask:    mask <= cmd_bus.wdata[3:0];
                dma_pkg::cmd_clr_mask:       mask <= '0;
                dma_pkg::cmd_clr_byte_ptr:   byte_ptr <= 1'b0;
                default: ;
            endcase
            // Terminal count wins over a status read in the same cycle
            if (chan_bus.step && count_zero) begin
                tc[sel]      <= 1'b1;
                request[sel] <= 1'b0;
                if (!autoinit) begin
                    mask[sel] <= 1'b1;
                end
            end
        end
    end

    // Address and count registers
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `DMA_CHANNELS; i++) begin
                base_addr[i]  <= '0;
                cur_addr[i]   <= '0;
                base_count[i] <= '0;
                cur_count[i]  <= '0;
            end
        end else if (master_clear) begin
            for (int i = 0; i < `DMA_CHANNELS; i++) begin
                base_addr[i]  <= '0;
                cur_addr[i]   <= '0;
                base_count[i] <= '0;
                cur_count[i]  <= '0;
            end
        end else begin
            if (cmd_bus.cmd == dma_pkg::cmd_wr_base_addr) begin
                base_addr[ch][byte_lsb +: `DMA_DATA_W] <= cmd_bus.wdata;
                cur_addr[ch][byte_lsb +: `DMA_DATA_W]  <= cmd_bus.wdata;
            end
            if (cmd_bus.cmd == dma_pkg::cmd_wr_base_count) begin
                base_count[ch][byte_lsb +: `DMA_DATA_W] <= cmd_bus.wdata;
                cur_count[ch][byte_lsb +: `DMA_DATA_W]  <= cmd_bus.wdata;
            end
            if (chan_bus.step) begin
                if (count_zero && autoinit) begin
                    cur_addr[sel]  <= base_addr[sel];
                    cur_count[sel] <= base_count[sel];
                end else begin
                    cur_addr[sel]  <= decrement ? cur_addr[sel] - 1'b1 : cur_addr[sel] + 1'b1;
                    cur_count[sel] <= cur_count[sel] - 1'b1;
                end
            end
        end
    end

    always_comb begin
        case (cmd_bus.cmd)
            dma_pkg::cmd_rd_cur_addr:  cmd_bus.rdata = cur_addr[ch][byte_lsb +: `DMA_DATA_W];
            dma_pkg::cmd_rd_cur_count: cmd_bus.rdata = cur_count[ch][byte_lsb +: `DMA_DATA_W];
            dma_pkg::cmd_rd_status:    cmd_bus.rdata = {dreq, tc};
            default:                   cmd_bus.rdata = '0;
        endcase
    end

    assign data_out = cmd_bus.rdata;

    assign chan_bus.ready           = (dreq | request) & ~mask & {`DMA_CHANNELS{~ctrl_disable}};
    assign chan_bus.current_address = cur_addr[sel];
    assign chan_bus.xfer_type       = dma_pkg::xfer_type_e'(mode_q[sel][1:0]);
    assign chan_bus.terminal        = count_zero;

endmodule

`default_nettype wire

/* logic/dma_params.svh */
// Channel count and bus widths for the DMA controller
`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

// Fixed by the register address map
`define DMA_CHANNELS 4

// Per-channel address and word count registers
`define DMA_ADDR_W 16
`define DMA_COUNT_W 16

// Host register port
`define DMA_DATA_W 8
`define DMA_REG_ADDR_W 4

`endif

/* logic/dma_pkg.sv */
// Register command, transfer type and engine state enums for the DMA controller
`default_nettype none

package dma_pkg;

    // One decoded host register operation
    typedef enum logic [3:0] {
        cmd_none,
        cmd_wr_base_addr,
        cmd_wr_base_count,
        cmd_rd_cur_addr,
        cmd_rd_cur_count,
        cmd_wr_command,
        cmd_rd_status,
        cmd_wr_request,
        cmd_wr_single_mask,
        cmd_wr_mode,
        cmd_wr_all_mask,
        cmd_clr_byte_ptr,
        cmd_master_clear,
        cmd_clr_mask
    } reg_cmd_e;

    // Mode bits 3:2, 2'b11 is illegal
    typedef enum logic [1:0] {
        xfer_verify = 2'b00,
        xfer_write  = 2'b01,
        xfer_read   = 2'b10
    } xfer_type_e;

    typedef enum logic [1:0] {
        st_idle,
        st_address,
        st_grant
    } engine_state_e;

endpackage

`default_nettype wire

/* logic/dma_reg_if.sv */
// Decoder-to-register and register-to-engine interfaces with their modports
`default_nettype none
`include "dma_params.svh"

interface dma_cmd_if;
    dma_pkg::reg_cmd_e        cmd;
    logic [1:0]               channel;
    logic [`DMA_DATA_W-1:0]   wdata;
    // Pulses once after a host read finishes
    logic                     read_end;
    logic [`DMA_DATA_W-1:0]   rdata;

    modport decoder (
        output cmd, channel, wdata, read_end,
        input  rdata
    );

    modport regs (
        input  cmd, channel, wdata, read_end,
        output rdata
    );
endinterface

interface dma_chan_if;
    logic [`DMA_CHANNELS-1:0] ready;
    logic [`DMA_ADDR_W-1:0]   current_address;
    dma_pkg::xfer_type_e      xfer_type;
    logic                     terminal;
    logic [1:0]               select;
    logic                     step;
    logic                     busy;

    modport regs (
        output ready, current_address, xfer_type, terminal,
        input  select, step
    );

    modport engine (
        input  ready, current_address, xfer_type, terminal,
        output select, step, busy
    );
endinterface

`default_nettype wire

/* logic/dma_top.sv */
// DMA controller top level joining the bus decoder, register file and transfer engine
`default_nettype none
`include "dma_params.svh"

module dma_top (
    input  wire logic                       clock,
    input  wire logic                       reset,
    // Host register port
    input  wire logic                       chip_select_n,
    input  wire logic                       io_read_n,
    input  wire logic                       io_write_n,
    input  wire logic [`DMA_REG_ADDR_W-1:0] address,
    input  wire logic [`DMA_DATA_W-1:0]     data_in,
    output logic [`DMA_DATA_W-1:0]          data_out,
    // Peripheral handshake
    input  wire logic [`DMA_CHANNELS-1:0]   dreq,
    output logic [`DMA_CHANNELS-1:0]        dack,
    // Memory side
    output logic                            aen,
    output logic [`DMA_ADDR_W-1:0]          mem_address,
    output logic                            mem_read,
    output logic                            mem_write,
    output logic                            terminal_count
);

    dma_cmd_if  cmd_bus ();
    dma_chan_if chan_bus ();

    dma_bus_control bus_control0 (
        .clock         (clock),
        .reset         (reset),
        .chip_select_n (chip_select_n),
        .io_read_n     (io_read_n),
        .io_write_n    (io_write_n),
        .address       (address),
        .data_in       (data_in),
        .lock          (chan_bus.busy),
        .cmd_bus       (cmd_bus.decoder)
    );

    dma_channel_regs channel_regs0 (
        .clock    (clock),
        .reset    (reset),
        .cmd_bus  (cmd_bus.regs),
        .chan_bus (chan_bus.regs),
        .dreq     (dreq),
        .data_out (data_out)
    );

    dma_transfer_engine transfer_engine0 (
        .clock          (clock),
        .reset          (reset),
        .chan_bus       (chan_bus.engine),
        .dreq           (dreq),
        .dack           (dack),
        .aen            (aen),
        .mem_address    (mem_address),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .terminal_count (terminal_count)
    );

endmodule

`default_nettype wire

/* logic/dma_transfer_engine.sv */
// Transfer FSM with fixed priority and the four-phase dreq/dack handshake
`default_nettype none
`include "dma_params.svh"

module dma_transfer_engine (
    input  wire logic                     clock,
    input  wire logic                     reset,
    dma_chan_if.engine                    chan_bus,
    input  wire logic [`DMA_CHANNELS-1:0] dreq,
    output logic [`DMA_CHANNELS-1:0]      dack,
    output logic                          aen,
    output logic [`DMA_ADDR_W-1:0]        mem_address,
    output logic                          mem_read,
    output logic                          mem_write,
    output logic                          terminal_count
);

    dma_pkg::engine_state_e state;
    logic [1:0]             sel;
    logic [1:0]             pick;
    logic [`DMA_ADDR_W-1:0] address_q;
    logic                   tc_q;
    logic                   in_grant;

    // Channel 0 has the highest priority
    always_comb begin
        pick = 2'd0;
        for (int i = `DMA_CHANNELS - 1; i >= 0; i--) begin
            if (chan_bus.ready[i]) begin
                pick = i[1:0];
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= dma_pkg::st_idle;
            sel   <= 2'd0;
            tc_q  <= 1'b0;
        end else begin
            case (state)
                dma_pkg::st_idle: begin
                    if (|chan_bus.ready) begin
                        sel   <= pick;
                        state <= dma_pkg::st_address;
                    end
                end
                dma_pkg::st_address: begin
                    // Count as seen by the step that fires here
                    tc_q  <= chan_bus.terminal;
                    state <= dma_pkg::st_grant;
                end
                dma_pkg::st_grant: begin
                    if (!dreq[sel]) begin
                        state <= dma_pkg::st_idle;
                    end
                end
                default: state <= dma_pkg::st_idle;
            endcase
        end
    end

    // Current address moves on at the step, keep the one being served
    always_ff @(posedge clock) begin
        if (state == dma_pkg::st_address) begin
            address_q <= chan_bus.current_address;
        end
    end

    assign in_grant = (state == dma_pkg::st_grant);

    assign chan_bus.select = sel;
    assign chan_bus.step   = (state == dma_pkg::st_address);
    assign chan_bus.busy   = (state != dma_pkg::st_idle);

    assign dack           = in_grant ? (`DMA_CHANNELS'(1) << sel) : '0;
    assign aen            = (state != dma_pkg::st_idle);
    assign mem_read       = in_grant && (chan_bus.xfer_type == dma_pkg::xfer_read);
    assign mem_write      = in_grant && (chan_bus.xfer_type == dma_pkg::xfer_write);
    assign terminal_count = in_grant & tc_q;

    always_comb begin
        if (state == dma_pkg::st_address) begin
            mem_address = chan_bus.current_address;
        end else if (in_grant) begin
            mem_address = address_q;
        end else begin
            mem_address = '0;
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f filelist.f --top-module dma_tb -o dma_sim
./obj_dir/dma_sim | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* sim/dma_clock_gen.sv */
// Testbench clock and power-on reset generator
`default_nettype none

module dma_clock_gen (
    output logic clock,
    output logic reset
);

    localparam int half_period  = 50;
    localparam int reset_cycles = 16;

    initial begin
        clock = 1'b0;
        forever #half_period clock = ~clock;
    end

    // Release just after an edge, in step with the stimulus
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        #10;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

/* sim/dma_tb.sv */
// DMA controller testbench with host bus tasks, peripheral model, reference model and checker
`default_nettype none
`include "dma_params.svh"

module dma_tb;

    localparam int timeout_cycles = 2000 * 6;
    localparam int drive_delay    = 10;
    localparam logic [3:0] addr_command     = 4'h8;
    localparam logic [3:0] addr_status      = 4'h8;
    localparam logic [3:0] addr_request     = 4'h9;
    localparam logic [3:0] addr_single_mask = 4'ha;
    localparam logic [3:0] addr_mode        = 4'hb;
    localparam logic [3:0] addr_clr_ptr     = 4'hc;
    localparam logic [3:0] addr_master_clr  = 4'hd;
    localparam logic [3:0] addr_clr_mask    = 4'he;
    localparam logic [3:0] addr_all_mask    = 4'hf;

    typedef struct packed {
        logic [`DMA_ADDR_W-1:0]  addr;
        logic [`DMA_COUNT_W-1:0] count;
        logic                    tc;
        logic                    masked;
    } expect_t;

    logic                       clock;
    logic                       reset;
    logic                       chip_select_n;
    logic                       io_read_n;
    logic                       io_write_n;
    logic [`DMA_REG_ADDR_W-1:0] address;
    logic [`DMA_DATA_W-1:0]     data_in;
    logic [`DMA_DATA_W-1:0]     data_out;
    logic [`DMA_CHANNELS-1:0]   dreq;
    logic [`DMA_CHANNELS-1:0]   dack;
    logic                       aen;
    logic [`DMA_ADDR_W-1:0]     mem_address;
    logic                       mem_read;
    logic                       mem_write;
    logic                       terminal_count;
    logic                       any_dack;

    // What each channel was programmed with, for the reference model
    logic [15:0]         trk_addr  [4];
    logic [15:0]         trk_count [4];
    logic                trk_dec   [4];
    logic                trk_auto  [4];
    dma_pkg::xfer_type_e trk_type  [4];
    int                  xfer_idx  [4];
    int                  grant_order [$];

    int seed = 86;
    int errors = 0;
    int checks = 0;
    int test_num = 0;
    int test_start_errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int cycles = 0;

    dma_clock_gen clock_gen0 (.clock(clock), .reset(reset));

    dma_top dut0 (
        .clock(clock), .reset(reset), .chip_select_n(chip_select_n), .io_read_n(io_read_n),
        .io_write_n(io_write_n), .address(address), .data_in(data_in), .data_out(data_out),
        .dreq(dreq), .dack(dack), .aen(aen), .mem_address(mem_address), .mem_read(mem_read),
        .mem_write(mem_write), .terminal_count(terminal_count)
    );

    assign any_dack = |dack;

    // Walks the step rules n times from the programmed base values
    function automatic expect_t dma_expect(input logic [15:0] start_addr,
                                           input logic [15:0] start_count, input logic dec,
                                           input logic auto_init, input int n);
        expect_t e;
        e = '{addr: start_addr, count: start_count, tc: 1'b0, masked: 1'b0};
        for (int i = 0; i < n; i++) begin
            if (e.count == 16'h0000 && auto_init) begin
                e.tc    = 1'b1;
                e.addr  = start_addr;
                e.count = start_count;
            end else begin
                if (e.count == 16'h0000) begin
                    e.tc     = 1'b1;
                    e.masked = 1'b1;
                end
                e.addr  = dec ? e.addr - 16'd1 : e.addr + 16'd1;
                e.count = e.count - 16'd1;
            end
        end
        return e;
    endfunction

    task automatic flag_mismatch(input string name, input logic [15:0] got,
                                 input logic [15:0] expected);
        $display("[ERROR] %s got %h expected %h", name, got, expected);
        errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #drive_delay;
    endtask

    // Register takes the write two edges after the strobe rises
    task automatic write_reg(input logic [3:0] addr, input logic [7:0] data);
        chip_select_n = 1'b0;
        io_write_n    = 1'b0;
        address       = addr;
        data_in       = data;
        next_cycle();
        chip_select_n = 1'b1;
        io_write_n    = 1'b1;
        next_cycle();
        next_cycle();
    endtask

    task automatic check_read(input logic [3:0] addr, input logic [7:0] expected);
        logic [7:0] got;
        chip_select_n = 1'b0;
        io_read_n     = 1'b0;
        address       = addr;
        next_cycle();
        got           = data_out;
        chip_select_n = 1'b1;
        io_read_n     = 1'b1;
        next_cycle();
        next_cycle();
        checks++;
        if (got !== expected) flag_mismatch("data_out", 16'(got), 16'(expected));
    endtask

    task automatic program_channel(input int ch, input logic [15:0] base,
                                   input logic [15:0] count, input logic dec,
                                   input logic auto_init, input dma_pkg::xfer_type_e kind);
        write_reg(addr_clr_ptr, 8'h00);
        write_reg(4'(2 * ch), base[7:0]);
        write_reg(4'(2 * ch), base[15:8]);
        write_reg(4'(2 * ch + 1), count[7:0]);
        write_reg(4'(2 * ch + 1), count[15:8]);
        write_reg(addr_mode, {2'b00, dec, auto_init, kind, 2'(ch)});
        trk_addr[ch]  = base;
        trk_count[ch] = count;
        trk_dec[ch]   = dec;
        trk_auto[ch]  = auto_init;
        trk_type[ch]  = kind;
        xfer_idx[ch]  = 0;
    endtask

    // Peripheral side of the four-phase handshake for a set of channels
    task automatic serve_dreq(input logic [3:0] set);
        logic [3:0] pending;
        logic       aen_before;
        int         waited;
        pending = set;
        dreq    = dreq | set;
        while (pending != 4'b0000) begin
            waited     = 0;
            aen_before = 1'b0;
            while (dack == 4'b0000 && waited < 50) begin
                aen_before = aen;
                next_cycle();
                waited++;
            end
            if (dack == 4'b0000) begin
                report_failure($sformatf("No dack for pending dreq %b", pending));
                dreq    = dreq & ~pending;
                pending = 4'b0000;
            end else begin
                // Address phase with aen high comes just before dack
                if (aen_before !== 1'b1) flag_mismatch("aen", 16'(aen_before), 16'h0001);
                if (!$onehot(dack) || (dack & ~pending) != 4'b0000) begin
                    flag_mismatch("dack", 16'(dack), 16'(pending));
                end
                pending = pending & ~dack;
                dreq    = dreq & ~dack;
                while (dack != 4'b0000) next_cycle();
            end
        end
    endtask

    task automatic confirm_blocked(input int ch);
        logic seen;
        seen     = 1'b0;
        dreq[ch] = 1'b1;
        repeat (50) begin
            next_cycle();
            if (dack[ch]) seen = 1'b1;
        end
        dreq[ch] = 1'b0;
        next_cycle();
        if (seen) report_failure($sformatf("Channel %0d was granted while blocked", ch));
    endtask

    task automatic wait_transfers(input int ch, input int n);
        int waited;
        waited = 0;
        while ((xfer_idx[ch] < n || aen) && waited < 2000) begin
            next_cycle();
            waited++;
        end
        if (waited >= 2000) report_failure("Software request transfers did not finish");
    endtask

    task automatic finish_test(input string name);
        test_num++;
        if (errors == test_start_errors) begin
            $display("Test %0d %s: passed", test_num, name);
            tests_passed++;
        end else begin
            $display("Test %0d %s: %0d errors", test_num, name, errors - test_start_errors);
            tests_failed++;
        end
        test_start_errors = errors;
    endtask

    // Compares each grant against the reference model
    always begin : grant_checker
        int      ch;
        expect_t e;
        @(posedge any_dack);
        @(negedge clock);
        ch = 0;
        for (int i = 0; i < 4; i++) begin
            if (dack[i]) ch = i;
        end
        e = dma_expect(trk_addr[ch], trk_count[ch], trk_dec[ch], trk_auto[ch], xfer_idx[ch]);
        checks++;
        if (mem_address !== e.addr) flag_mismatch("mem_address", mem_address, e.addr);
        if (mem_read !== (trk_type[ch] == dma_pkg::xfer_read)) begin
            flag_mismatch("mem_read", 16'(mem_read), 16'(trk_type[ch] == dma_pkg::xfer_read));
        end
        if (mem_write !== (trk_type[ch] == dma_pkg::xfer_write)) begin
            flag_mismatch("mem_write", 16'(mem_write), 16'(trk_type[ch] == dma_pkg::xfer_write));
        end
        if (terminal_count !== (e.count == 16'h0000)) begin
            flag_mismatch("terminal_count", 16'(terminal_count), 16'(e.count == 16'h0000));
        end
        grant_order.push_back(ch);
        xfer_idx[ch]++;
    end

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("Timeout after %0d cycles, the run did not finish", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin : stimulus
        logic [15:0] a;
        logic [15:0] c;
        expect_t     e;
        chip_select_n = 1'b1;
        io_read_n     = 1'b1;
        io_write_n    = 1'b1;
        address       = 4'h0;
        data_in       = 8'h00;
        dreq          = 4'b0000;
        @(negedge reset);
        next_cycle();
        if (aen !== 1'b0) flag_mismatch("aen", 16'(aen), 16'h0000);

        for (int ch = 0; ch < 4; ch++) begin
            a = 16'($random(seed));
            c = 16'($random(seed)) | 16'h0010;
            program_channel(ch, a, c, 1'b0, 1'b0, dma_pkg::xfer_verify);
            check_read(4'(2 * ch), a[7:0]);
            check_read(4'(2 * ch), a[15:8]);
            check_read(4'(2 * ch + 1), c[7:0]);
            check_read(4'(2 * ch + 1), c[15:8]);
        end
        // Clearing the pointer halfway restarts at the low byte
        check_read(4'd6, trk_addr[3][7:0]);
        write_reg(addr_clr_ptr, 8'h00);
        check_read(4'd6, trk_addr[3][7:0]);
        write_reg(addr_clr_ptr, 8'h00);
        finish_test("byte pointer and read-back");

        for (int ch = 0; ch < 4; ch++) begin
            program_channel(ch, 16'($random(seed)), 16'($random(seed)) | 16'h0010,
                            1'(ch % 2), 1'b0, dma_pkg::xfer_type_e'(2'(ch % 3)));
        end
        write_reg(addr_clr_mask, 8'h00);
        for (int ch = 0; ch < 4; ch++) begin
            repeat (3) serve_dreq(4'(1 << ch));
        end
        finish_test("single transfers");

        c = 16'(($random(seed) & 7) + 1);
        program_channel(1, 16'($random(seed)), c, 1'b0, 1'b0, dma_pkg::xfer_write);
        repeat (c + 1) serve_dreq(4'b0010);
        e = dma_expect(trk_addr[1], trk_count[1], 1'b0, 1'b0, xfer_idx[1]);
        check_read(addr_status, {6'd0, e.tc, 1'b0});
        check_read(addr_status, 8'h00);
        // Without autoinit the channel masks itself at terminal count
        if (e.masked) begin
            confirm_blocked(1);
        end else begin
            serve_dreq(4'b0010);
        end
        program_channel(2, 16'($random(seed)), c, 1'b0, 1'b1, dma_pkg::xfer_read);
        repeat (c + 2) serve_dreq(4'b0100);
        check_read(addr_status, 8'h04);
        finish_test("terminal count and autoinit");

        write_reg(addr_all_mask, 8'h0f);
        confirm_blocked(0);
        write_reg(addr_single_mask, 8'h02);
        serve_dreq(4'b0100);
        confirm_blocked(0);
        write_reg(addr_clr_mask, 8'h00);
        grant_order.delete();
        serve_dreq(4'b1111);
        if (grant_order.size() != 4) begin
            report_failure($sformatf("Expected 4 grants, saw %0d", grant_order.size()));
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (grant_order[i] != i) begin
                    flag_mismatch("grant channel", 16'(grant_order[i]), 16'(i));
                end
            end
        end
        write_reg(addr_single_mask, 8'h07);
        confirm_blocked(3);
        finish_test("masking and priority");

        write_reg(addr_master_clr, 8'h00);
        for (int r = 0; r < 8; r++) begin
            check_read(4'(r), 8'h00);
            check_read(4'(r), 8'h00);
        end
        check_read(addr_status, 8'h00);
        confirm_blocked(0);
        program_channel(0, 16'($random(seed)), 16'h0020, 1'b0, 1'b0, dma_pkg::xfer_read);
        write_reg(addr_command, 8'h04);
        write_reg(addr_clr_mask, 8'h00);
        confirm_blocked(0);
        write_reg(addr_command, 8'h00);
        serve_dreq(4'b0001);
        finish_test("master clear and disable");

        c = 16'(($random(seed) & 7) + 1);
        program_channel(3, 16'($random(seed)), c, 1'b0, 1'b0, dma_pkg::xfer_write);
        write_reg(addr_request, 8'h07);
        wait_transfers(3, c + 1);
        check_read(addr_status, 8'h08);
        // A cleared request must not restart transfers once unmasked
        write_reg(addr_single_mask, 8'h03);
        repeat (50) next_cycle();
        if (xfer_idx[3] != c + 1) begin
            report_failure($sformatf("Channel 3 made %0d transfers, not %0d",
                                     xfer_idx[3], c + 1));
        end
        finish_test("software request");

        $display("Tests passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
